/* verilog/obj_geom_pkg.sv */
// sprite geometry constants: tile size and field widths.
`default_nettype none

package obj_geom_pkg;

    // tiles are square.
    localparam int TILE_PX = 16;

    // tile code as stored in the table and sent to the draw port.
    localparam int CODE_W = 16;

    // screen x, 9 bits wide and wrapping past 511.
    localparam int X_W = 9;

    // object y keeps one extra bit for the wrap test.
    localparam int Y_W = 10;

    localparam int LINE_W = 9; // render line.
    localparam int SUB_W = 4; // row inside a tile, log2 of TILE_PX.
    localparam int SPAN_W = 4; // tile_n / tile_m span fields.
    localparam int PAL_W = 5; // palette select.

endpackage

`default_nettype wire

/* verilog/obj_table_pkg.sv */
// object table format: word offsets, attribute bit fields and end marker.
`default_nettype none

package obj_table_pkg;

    // each entry is four 16-bit words.
    localparam int WORDS_PER_OBJ = 4;

    // word offsets inside an entry, in fetch order.
    localparam logic [1:0] WORD_X = 2'd0;
    localparam logic [1:0] WORD_Y = 2'd1;
    localparam logic [1:0] WORD_CODE = 2'd2;
    localparam logic [1:0] WORD_ATTR = 2'd3; // fetched last.

    // attribute word layout.
    localparam int ATTR_PAL_LSB = 0; // palette, bits 4:0.
    localparam int ATTR_HFLIP = 5;
    localparam int ATTR_VFLIP = 6;
    localparam int ATTR_N_LSB = 8; // column span, bits 11:8.
    localparam int ATTR_M_LSB = 12; // row span, bits 15:12.

    // attribute high byte of this value closes the table.
    // it overlaps both span fields, so no real entry can carry it
    // with a 16x16 span.
    localparam logic [7:0] END_MARK = 8'hFF;

endpackage

`default_nettype wire

/* verilog/obj_tile_if.sv */
// tile column bus from the table scanner to the match and draw stages.
`timescale 1ns/1ns
`default_nettype none

interface obj_tile_if;

    logic                              strobe; // one cycle per column.
    logic [obj_geom_pkg::CODE_W-1:0]   obj_code;
    logic [obj_geom_pkg::SPAN_W-1:0]   tile_n; // columns minus one.
    logic [obj_geom_pkg::SPAN_W-1:0]   tile_m; // rows minus one.
    logic [obj_geom_pkg::SPAN_W-1:0]   n; // current column.
    logic                              vflip;
    logic [obj_geom_pkg::Y_W-1:0]      obj_y;
    logic [obj_geom_pkg::LINE_W-1:0]   vrender; // line latched at start.

    // sideband, only the draw stage looks at these.
    logic [obj_geom_pkg::X_W-1:0]      obj_x;
    logic                              hflip;
    logic [obj_geom_pkg::PAL_W-1:0]    pal;

    // scanner drives every field.
    modport scan (
        output strobe, obj_code, tile_n, tile_m, n, vflip, obj_y, vrender,
        output obj_x, hflip, pal
    );

    // line hit test and code offset.
    modport match (
        input strobe, obj_code, tile_n, tile_m, n, vflip, obj_y, vrender
    );

    // x placement and draw strobe.
    modport draw (
        input strobe, tile_n, n, obj_x, hflip, pal
    );

endinterface

`default_nettype wire

/* verilog/obj_table_ram.sv */
// object table RAM: write port from outside, registered read for the scanner.
`timescale 1ns/1ns
`default_nettype none

module obj_table_ram #(
    parameter int OBJ_N = 64,
    localparam int DEPTH = OBJ_N * obj_table_pkg::WORDS_PER_OBJ,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we, // host write strobe.
    input  logic [AW-1:0] waddr,
    input  logic [15:0]   wdata,
    input  logic [AW-1:0] raddr,
    output logic [15:0]   rdata // valid one cycle after raddr.
);

    // entry k holds words 4k..4k+3.
    logic [15:0] mem [DEPTH];

    // write side.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read side, old data on a same-address write.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* verilog/obj_table_scan.sv */
// table scanner FSM: fetches each entry and issues one strobe per tile column.
`timescale 1ns/1ns
`default_nettype none

module obj_table_scan #(
    parameter int OBJ_N = 64,
    localparam int AW = $clog2(OBJ_N * obj_table_pkg::WORDS_PER_OBJ)
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start, // sampled only when idle.
    input  logic [obj_geom_pkg::LINE_W-1:0] vrender_in,
    output logic [AW-1:0]                   raddr,
    input  logic [15:0]                     rdata,
    output logic                            busy,
    output logic                            scan_end, // first done cycle.
    obj_tile_if.scan                        tile
);

    localparam int LW = obj_geom_pkg::LINE_W;
    localparam int XW = obj_geom_pkg::X_W;
    localparam int YW = obj_geom_pkg::Y_W;
    localparam int CW = obj_geom_pkg::CODE_W;
    localparam int SW = obj_geom_pkg::SPAN_W;
    localparam int PW = obj_geom_pkg::PAL_W;

    // draw side needs three more cycles to drain after the last strobe.
    localparam int DRAIN_CYC = 3;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;
    localparam logic [1:0] S_EMIT = 2'd2;
    localparam logic [1:0] S_DONE = 2'd3;

    logic [1:0]    state;
    logic [1:0]    wcnt; // word being returned; drain count in done.
    logic [AW-1:0] ptr; // address presented to the RAM.
    logic [SW-1:0] n_q; // column counter.
    logic          last_q; // current entry is the last one.
    logic          end_hit;
    logic [SW-1:0] span_n;

    // captured entry.
    logic [LW-1:0] vrender_q;
    logic [XW-1:0] x_q;
    logic [YW-1:0] y_q;
    logic [CW-1:0] code_q;
    logic [15:0]   attr_q;

    // end marker sits in the attribute high byte.
    assign end_hit = rdata[obj_table_pkg::ATTR_N_LSB +: 8] == obj_table_pkg::END_MARK;
    assign span_n = attr_q[obj_table_pkg::ATTR_N_LSB +: SW];

    // ptr runs one word ahead so the RAM latency hides inside the fetch.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            wcnt <= '0;
            ptr <= '0;
            n_q <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin // word 0 read issued on this edge.
                        state <= S_FETCH;
                        wcnt <= '0;
                        ptr <= ptr + 1'b1;
                    end
                end
                S_FETCH: begin
                    wcnt <= wcnt + 1'b1; // wraps to 0 after the attribute.
                    if (wcnt != obj_table_pkg::WORD_ATTR) begin
                        ptr <= ptr + 1'b1;
                    end else if (end_hit) begin
                        state <= S_DONE;
                        ptr <= '0;
                    end else begin
                        state <= S_EMIT;
                        n_q <= '0;
                        last_q <= (ptr == '0); // ptr wrapped past the table.
                    end
                end
                S_EMIT: begin
                    if (n_q == span_n) begin
                        if (last_q) begin
                            state <= S_DONE;
                            ptr <= '0;
                        end else begin
                            state <= S_FETCH; // next word 0 already read.
                            ptr <= ptr + 1'b1;
                        end
                    end else begin
                        n_q <= n_q + 1'b1;
                    end
                end
                default: begin // S_DONE, hold busy until line_done.
                    wcnt <= wcnt + 1'b1;
                    if (wcnt == 2'(DRAIN_CYC)) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // entry words, captured as they come back.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            vrender_q <= vrender_in;
        end
        if (state == S_FETCH) begin
            case (wcnt)
                obj_table_pkg::WORD_X: x_q <= rdata[XW-1:0];
                obj_table_pkg::WORD_Y: y_q <= rdata[YW-1:0];
                obj_table_pkg::WORD_CODE: code_q <= rdata[CW-1:0];
                default: attr_q <= rdata;
            endcase
        end
    end

    assign raddr = ptr;
    assign busy = state != S_IDLE;
    assign scan_end = (state == S_DONE) && (wcnt == 2'd0);

    // column bus.
    assign tile.strobe = state == S_EMIT; // one per column.
    assign tile.obj_code = code_q;
    assign tile.tile_n = span_n;
    assign tile.tile_m = attr_q[obj_table_pkg::ATTR_M_LSB +: SW];
    assign tile.n = n_q;
    assign tile.vflip = attr_q[obj_table_pkg::ATTR_VFLIP];
    assign tile.obj_y = y_q;
    assign tile.vrender = vrender_q;
    assign tile.obj_x = x_q;
    assign tile.hflip = attr_q[obj_table_pkg::ATTR_HFLIP];
    assign tile.pal = attr_q[obj_table_pkg::ATTR_PAL_LSB +: PW];

endmodule

`default_nettype wire

/* verilog/obj_tile_match.sv */
// tile match stage: line hit test, tile code with row and column, row in tile.
`timescale 1ns/1ns
`default_nettype none

module obj_tile_match (
    input  logic                            clk,
    input  logic                            rst,
    obj_tile_if.match                       tile,
    output logic [obj_geom_pkg::SUB_W-1:0]  vsub, // row inside the tile.
    output logic                            inzone, // column covers the line.
    output logic [obj_geom_pkg::CODE_W-1:0] code_mn
);

    localparam int YW = obj_geom_pkg::Y_W;
    localparam int CW = obj_geom_pkg::CODE_W;
    localparam int SW = obj_geom_pkg::SPAN_W;
    localparam int SUBW = obj_geom_pkg::SUB_W;
    localparam int TILE_PX = obj_geom_pkg::TILE_PX;

    logic [YW-1:0]   vs; // line, zero extended.
    logic [YW-1:0]   bottom; // first line below the object.
    logic [YW-1:0]   ycross; // line minus y.
    logic [SW-1:0]   m;
    logic [SW-1:0]   mflip;
    logic [SW-1:0]   row;
    logic [SUBW-1:0] vd;

    always_comb begin
        vs = {1'b0, tile.vrender};
        bottom = tile.obj_y + YW'(({1'b0, tile.tile_m} + 5'd1) * TILE_PX);
        ycross = vs - tile.obj_y;
        m = ycross[SUBW +: SW]; // tile row hit by the line.
        vd = ycross[SUBW-1:0];
        mflip = tile.tile_m - m; // rows count from the bottom.
        row = tile.vflip ? mflip : m;
    end

    // results land one cycle after the strobe.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
            vsub <= '0;
            code_mn <= '0;
        end else if (tile.strobe) begin
            // y past 240 counts as negative, so it wraps onto the top lines.
            inzone <= (bottom > vs) && (vs >= tile.obj_y || tile.obj_y > 10'h0f0);
            vsub <= vd ^ {SUBW{tile.vflip}};
            // offsets only where the span is larger than one tile.
            case ({tile.tile_m != '0, tile.tile_n != '0})
                2'b00: code_mn <= tile.obj_code;
                2'b01: code_mn <= tile.obj_code + {{(CW - SW){1'b0}}, tile.n};
                2'b10: begin
                    code_mn <= tile.obj_code + {{(CW - 2 * SW){1'b0}}, row, {SW{1'b0}}};
                end
                default: begin
                    code_mn <= tile.obj_code + {{(CW - 2 * SW){1'b0}}, row, tile.n};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/obj_draw_out.sv */
// draw output stage: in-zone filter, column x placement, draw strobe, line_done.
`timescale 1ns/1ns
`default_nettype none

module obj_draw_out (
    input  logic                            clk,
    input  logic                            rst,
    obj_tile_if.draw                        tile,
    input  logic [obj_geom_pkg::SUB_W-1:0]  vsub,
    input  logic                            inzone,
    input  logic [obj_geom_pkg::CODE_W-1:0] code_mn,
    input  logic                            scan_end,
    output logic                            draw_valid,
    output logic [obj_geom_pkg::CODE_W-1:0] draw_code,
    output logic [obj_geom_pkg::SUB_W-1:0]  draw_vsub,
    output logic [obj_geom_pkg::X_W-1:0]    draw_x,
    output logic [obj_geom_pkg::PAL_W-1:0]  draw_pal,
    output logic                            draw_hflip,
    output logic                            line_done
);

    localparam int XW = obj_geom_pkg::X_W;
    localparam int SW = obj_geom_pkg::SPAN_W;
    localparam int PW = obj_geom_pkg::PAL_W;
    localparam int TILE_PX = obj_geom_pkg::TILE_PX;

    // sideband copy, lines up with the match registers.
    logic          stb_d;
    logic [SW-1:0] tile_n_d;
    logic [SW-1:0] n_d;
    logic [XW-1:0] obj_x_d;
    logic          hflip_d;
    logic [PW-1:0] pal_d;
    logic [SW-1:0] col;
    logic          end_d1;
    logic          end_d2;

    // columns run right to left under hflip, code order unchanged.
    assign col = hflip_d ? tile_n_d - n_d : n_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stb_d <= 1'b0;
            draw_valid <= 1'b0;
            end_d1 <= 1'b0;
            end_d2 <= 1'b0;
            line_done <= 1'b0;
        end else begin
            stb_d <= tile.strobe;
            draw_valid <= stb_d & inzone; // out-of-zone columns dropped.
            end_d1 <= scan_end;
            end_d2 <= end_d1;
            line_done <= end_d2; // lands after the last draw.
        end
    end

    always_ff @(posedge clk) begin
        tile_n_d <= tile.tile_n;
        n_d <= tile.n;
        obj_x_d <= tile.obj_x;
        hflip_d <= tile.hflip;
        pal_d <= tile.pal;
        draw_code <= code_mn;
        draw_vsub <= vsub;
        draw_x <= obj_x_d + XW'(col * TILE_PX); // wraps at 9 bits.
        draw_pal <= pal_d;
        draw_hflip <= hflip_d;
    end

endmodule

`default_nettype wire

/* verilog/obj_line_engine.sv */
// sprite line engine top: table RAM, scanner, match and draw stages.
`timescale 1ns/1ns
`default_nettype none

module obj_line_engine #(
    parameter int OBJ_N = 64,
    localparam int AW = $clog2(OBJ_N * obj_table_pkg::WORDS_PER_OBJ)
) (
    input  logic                            clk,
    input  logic                            rst,
    // table write port, idle only.
    input  logic                            tbl_we,
    input  logic [AW-1:0]                   tbl_addr,
    input  logic [15:0]                     tbl_din,
    // line request.
    input  logic                            start,
    input  logic [obj_geom_pkg::LINE_W-1:0] vrender,
    // one pulse per visible tile.
    output logic                            draw_valid,
    output logic [obj_geom_pkg::CODE_W-1:0] draw_code,
    output logic [obj_geom_pkg::SUB_W-1:0]  draw_vsub,
    output logic [obj_geom_pkg::X_W-1:0]    draw_x,
    output logic [obj_geom_pkg::PAL_W-1:0]  draw_pal,
    output logic                            draw_hflip,
    output logic                            line_done,
    output logic                            busy
);

    logic [AW-1:0]                   raddr;
    logic [15:0]                     rdata;
    logic                            scan_end;
    logic [obj_geom_pkg::SUB_W-1:0]  vsub;
    logic                            inzone;
    logic [obj_geom_pkg::CODE_W-1:0] code_mn;

    obj_tile_if tile_bus ();

    obj_table_ram #(
        .OBJ_N (OBJ_N)
    ) u_ram (
        .clk   (clk),
        .we    (tbl_we),
        .waddr (tbl_addr),
        .wdata (tbl_din),
        .raddr (raddr),
        .rdata (rdata)
    );

    obj_table_scan #(
        .OBJ_N (OBJ_N)
    ) u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .vrender_in (vrender),
        .raddr      (raddr),
        .rdata      (rdata),
        .busy       (busy),
        .scan_end   (scan_end),
        .tile       (tile_bus.scan)
    );

    obj_tile_match u_match (
        .clk     (clk),
        .rst     (rst),
        .tile    (tile_bus.match),
        .vsub    (vsub),
        .inzone  (inzone),
        .code_mn (code_mn)
    );

    obj_draw_out u_draw (
        .clk        (clk),
        .rst        (rst),
        .tile       (tile_bus.draw),
        .vsub       (vsub),
        .inzone     (inzone),
        .code_mn    (code_mn),
        .scan_end   (scan_end),
        .draw_valid (draw_valid),
        .draw_code  (draw_code),
        .draw_vsub  (draw_vsub),
        .draw_x     (draw_x),
        .draw_pal   (draw_pal),
        .draw_hflip (draw_hflip),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

/* verification/obj_line_checker.sv */
// bound assertions on the line engine ports: reset quiet, pulse width, busy framing.
`timescale 1ns/1ns
`default_nettype none

module obj_line_checker (
    input logic clk,
    input logic rst,
    input logic draw_valid,
    input logic line_done,
    input logic busy
);

    // outputs held low by reset.
    a_reset_quiet: assert property (@(posedge clk) rst |=> !draw_valid && !line_done)
        else $error("draw_valid or line_done high while in reset");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) line_done |=> !line_done)
        else $error("line_done wider than one cycle");

    // draws only inside a scan.
    a_draw_busy: assert property (@(posedge clk) disable iff (rst) draw_valid |-> busy)
        else $error("draw_valid while busy is low");

    a_busy_fall: assert property (@(posedge clk) disable iff (rst) line_done |=> !busy)
        else $error("busy still high the cycle after line_done");

endmodule

`default_nettype wire

/* verification/obj_line_tb.sv */
// testbench for the sprite line engine with table load, line case loop and reference model.
`timescale 1ns/1ns
`default_nettype none

module obj_line_tb;

    localparam int OBJ_N = 64;
    localparam int AW = $clog2(OBJ_N * 4);
    localparam int N_OBJ = 8; // hand-made entries then filler.
    localparam int N_CASES = 14;
    localparam int DONE_LIMIT = 2000; // cycles.

    // {end, vflip, hflip, tile_m, tile_n, y}.
    localparam logic [20:0] OBJ_DESC [N_OBJ] = '{
        {1'b0, 1'b0, 1'b0, 4'd0, 4'd0, 10'd40}, // 1x1.
        {1'b0, 1'b0, 1'b0, 4'd2, 4'd0, 10'd100}, // three rows.
        {1'b0, 1'b1, 1'b0, 4'd2, 4'd0, 10'd160}, // three rows, vflip.
        {1'b0, 1'b0, 1'b0, 4'd0, 4'd3, 10'd60}, // four columns.
        {1'b0, 1'b0, 1'b1, 4'd0, 4'd3, 10'd80}, // four columns, hflip.
        {1'b0, 1'b0, 1'b0, 4'd1, 4'd0, 10'd1016}, // wraps onto lines 0..23.
        {1'b1, 1'b0, 1'b0, 4'd0, 4'd0, 10'd0}, // end marker.
        {1'b0, 1'b0, 1'b0, 4'd0, 4'd1, 10'd40} // hidden behind the marker.
    };

    // {render line, draws expected}.
    localparam logic [15:0] CASES [N_CASES] = '{
        {9'd40, 7'd1}, {9'd55, 7'd1}, {9'd56, 7'd0}, {9'd100, 7'd1},
        {9'd120, 7'd1}, {9'd147, 7'd1}, {9'd165, 7'd1}, {9'd200, 7'd1},
        {9'd60, 7'd4}, {9'd90, 7'd4}, {9'd3, 7'd1}, {9'd23, 7'd1},
        {9'd24, 7'd0}, {9'd300, 7'd0}
    };

    logic          clk;
    logic          rst;
    logic          tbl_we;
    logic [AW-1:0] tbl_addr;
    logic [15:0]   tbl_din;
    logic          start;
    logic [8:0]    vrender;
    logic          draw_valid;
    logic [15:0]   draw_code;
    logic [3:0]    draw_vsub;
    logic [8:0]    draw_x;
    logic [4:0]    draw_pal;
    logic          draw_hflip;
    logic          line_done;
    logic          busy;

    logic [15:0] shadow [OBJ_N * 4]; // copy of the table as written.
    logic [34:0] exp_q [$]; // {code, vsub, x, pal, hflip} in scan order.
    logic [31:0] lfsr;
    int          val_errs;
    int          tmo_errs;

    obj_line_engine #(.OBJ_N(OBJ_N)) DUT (.*);

    bind obj_line_engine obj_line_checker u_checker (.*);

    always #4 clk = ~clk;

    // galois form with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int cnt, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < cnt; i++) begin
            val = {val[14:0], lfsr[0]}; // one step per bit.
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic write_word(input int addr, input logic [15:0] data);
        @(posedge clk);
        tbl_we <= 1'b1;
        tbl_addr <= AW'(addr);
        tbl_din <= data;
        shadow[addr] = data;
    endtask

    task automatic load_table();
        logic [15:0] x;
        logic [15:0] pal;
        logic [15:0] code;
        logic [20:0] d;
        for (int k = 0; k < OBJ_N; k++) begin
            d = OBJ_DESC[k % N_OBJ];
            take_bits(9, x);
            take_bits(5, pal);
            take_bits(16, code);
            for (int w = 0; w < 4; w++) begin
                if (k >= N_OBJ) begin // filler unique per address.
                    write_word(4 * k + w, {8'(4 * k + w) ^ 8'hA5, 8'(4 * k + w)});
                end else if (w == 3) begin // m, n, 0, vflip, hflip, pal.
                    write_word(4 * k + w, d[20] ? {obj_table_pkg::END_MARK, 8'h00}
                        : {d[17:14], d[13:10], 1'b0, d[19], d[18], pal[4:0]});
                end else begin
                    write_word(4 * k + w, w == 0 ? x : (w == 1 ? {6'd0, d[9:0]} : code));
                end
            end
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // walks the written table with the line rules.
    task automatic build_expected(input logic [8:0] line);
        logic [15:0] attr;
        logic [9:0]  y;
        logic [9:0]  lv;
        logic [9:0]  dy;
        logic [3:0]  tn;
        logic [3:0]  tm;
        logic [3:0]  row;
        logic [15:0] code;
        logic [8:0]  xpos;
        exp_q.delete();
        lv = {1'b0, line};
        for (int k = 0; k < OBJ_N; k++) begin
            attr = shadow[4 * k + 3];
            if (attr[15:8] == obj_table_pkg::END_MARK) begin
                break;
            end
            y = shadow[4 * k + 1][9:0];
            tn = attr[11:8];
            tm = attr[15:12];
            dy = lv - y;
            row = attr[6] ? tm - dy[7:4] : dy[7:4]; // vflip counts rows upward.
            // above the bottom edge and below the top unless y wraps.
            if (lv < y + 10'(16 * (int'(tm) + 1)) && (lv >= y || y > 10'd240)) begin
                for (int c = 0; c <= int'(tn); c++) begin
                    code = shadow[4 * k + 2] + (tm != 4'd0 ? {8'd0, row, 4'd0} : 16'd0)
                        + (tn != 4'd0 ? 16'(c) : 16'd0);
                    xpos = shadow[4 * k][8:0] + 9'(16 * (attr[5] ? int'(tn) - c : c));
                    exp_q.push_back({code, dy[3:0] ^ {4{attr[6]}}, xpos, attr[4:0], attr[5]});
                end
            end
        end
    endtask

    task automatic idle_watch(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (busy || draw_valid || line_done) begin
                val_errs++;
                $display("FAIL %0t: activity with no scan, busy %b draw %b done %b",
                    $time, busy, draw_valid, line_done);
            end
        end
    endtask

    task automatic run_line(input logic [8:0] line, input int want);
        int          got;
        int          cyc;
        logic        done;
        logic [34:0] seen;
        logic [34:0] ref_d;
        build_expected(line);
        if (exp_q.size() != want) begin
            val_errs++;
            $display("FAIL %0t: line %0d model has %0d draws, case table %0d",
                $time, line, exp_q.size(), want);
        end
        @(posedge clk);
        start <= 1'b1;
        vrender <= line;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        start <= 1'b1; // second request while busy is dropped.
        vrender <= ~line; // line input stays changed for the rest of the scan.
        @(posedge clk);
        start <= 1'b0;
        got = 0;
        cyc = 0;
        done = 1'b0;
        while (!done && cyc < DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (draw_valid) begin
                got++;
                seen = {draw_code, draw_vsub, draw_x, draw_pal, draw_hflip};
                ref_d = exp_q.size() != 0 ? exp_q.pop_front() : 35'h0;
                if (seen !== ref_d) begin
                    val_errs++;
                    $display("FAIL %0t: line %0d draw %0d got %h, expected %h",
                        $time, line, got, seen, ref_d);
                end
            end
            done = line_done;
        end
        if (!done) begin
            tmo_errs++;
            $display("Timed out waiting for line_done on line %0d.", line);
        end else if (got != want) begin
            val_errs++;
            $display("FAIL %0t: line %0d gave %0d draws, expected %0d", $time, line, got, want);
        end
        idle_watch(8); // no second scan from the dropped start.
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        tbl_we = 1'b0;
        tbl_addr = '0;
        tbl_din = '0;
        start = 1'b0;
        vrender = '0;
        lfsr = 32'h1462_1297;
        val_errs = 0;
        tmo_errs = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        idle_watch(20);
        load_table();
        for (int i = 0; i < N_CASES; i++) begin
            run_line(CASES[i][15:7], int'(CASES[i][6:0]));
        end
        $display("errors: %0d value, %0d timeout", val_errs, tmo_errs);
        if (val_errs == 0 && tmo_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/obj_geom_pkg.sv
verilog/obj_table_pkg.sv
verilog/obj_tile_if.sv
verilog/obj_table_ram.sv
verilog/obj_table_scan.sv
verilog/obj_tile_match.sv
verilog/obj_draw_out.sv
verilog/obj_line_engine.sv
verification/obj_line_checker.sv
verification/obj_line_tb.sv

/* Makefile */
# Verilator build, run and lint for the sprite line engine.

VERILATOR  ?= verilator
TOP        ?= obj_line_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
